// ==== rtl/riscv_pkg.sv ====
package riscv_pkg;

  localparam int DATA_WIDTH  = 128;
  localparam int ADDR        = 16;                       // byte address
  localparam int BYTE_OFF    = 4;                        // 16 bytes per block
  localparam int INDEX       = 6;
  localparam int TAG         = ADDR - BYTE_OFF - INDEX;  // 6 bits
  localparam int S_ADDR      = ADDR - BYTE_OFF;          // block address
  localparam int LINES       = 2**INDEX;
  localparam int MEM_LATENCY = 4;
  localparam int MEM_DEPTH   = 2**S_ADDR;

  // latency counter of the memory models
  localparam int               LAT_W    = $clog2(MEM_LATENCY);
  localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(MEM_LATENCY - 1);

  typedef logic [DATA_WIDTH-1:0] block_t;
  typedef logic [63:0]           dword_t;
  typedef logic [31:0]           instr_t;
  typedef logic [ADDR-1:0]       addr_t;
  typedef logic [S_ADDR-1:0]     blk_addr_t;
  typedef logic [TAG-1:0]        tag_t;
  typedef logic [INDEX-1:0]      index_t;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_WRITEBACK,
    DC_REFILL,
    DC_RESPOND
  } dcache_state_t;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_REFILL,
    IC_RESPOND
  } icache_state_t;

endpackage

// ==== rtl/riscv_dcache.sv ====
`timescale 1ns/100ps

module riscv_dcache (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst_n,
  input  logic                  i_dc_rd,
  input  logic                  i_dc_wr,
  input  riscv_pkg::addr_t      i_dc_addr,
  input  riscv_pkg::dword_t     i_dc_wdata,
  output riscv_pkg::dword_t     o_dc_rdata,
  output logic                  o_dc_done,
  output logic                  o_mem_rden,
  output logic                  o_mem_wren,
  output riscv_pkg::blk_addr_t  o_mem_addr,
  output riscv_pkg::block_t     o_mem_wdata,
  input  riscv_pkg::block_t     i_mem_rdata,
  input  logic                  i_mem_ready
);

  riscv_pkg::dcache_state_t state;
  riscv_pkg::dcache_state_t next_state;

  riscv_pkg::block_t data_mem [riscv_pkg::LINES];
  riscv_pkg::tag_t   tag_mem  [riscv_pkg::LINES];
  logic [riscv_pkg::LINES-1:0] valid;
  logic [riscv_pkg::LINES-1:0] dirty;

  riscv_pkg::tag_t   tag;
  riscv_pkg::index_t idx;
  logic              dw_sel;  // upper or lower doubleword
  logic              req;
  logic              hit;
  riscv_pkg::block_t line;

  // request is held by the core until done
  assign tag    = i_dc_addr[riscv_pkg::ADDR-1 -: riscv_pkg::TAG];
  assign idx    = i_dc_addr[riscv_pkg::BYTE_OFF +: riscv_pkg::INDEX];
  assign dw_sel = i_dc_addr[3];
  assign req    = i_dc_rd | i_dc_wr;

  assign line = data_mem[idx];
  assign hit  = valid[idx] && (tag_mem[idx] == tag);

  assign o_dc_rdata = dw_sel ? line[127:64] : line[63:0];
  assign o_dc_done  = (state == riscv_pkg::DC_RESPOND);

  assign o_mem_wren  = (state == riscv_pkg::DC_WRITEBACK);
  assign o_mem_rden  = (state == riscv_pkg::DC_REFILL);
  assign o_mem_wdata = line;
  // victim goes back to where it came from
  assign o_mem_addr  = o_mem_wren ? {tag_mem[idx], idx} : {tag, idx};

  always_comb begin
    next_state = state;
    case (state)
      riscv_pkg::DC_IDLE: begin
        if (req) next_state = riscv_pkg::DC_LOOKUP;
      end
      riscv_pkg::DC_LOOKUP: begin
        if (hit) begin
          next_state = riscv_pkg::DC_RESPOND;
        end else if (valid[idx] && dirty[idx]) begin
          next_state = riscv_pkg::DC_WRITEBACK;
        end else begin
          next_state = riscv_pkg::DC_REFILL;
        end
      end
      riscv_pkg::DC_WRITEBACK: begin
        if (i_mem_ready) next_state = riscv_pkg::DC_REFILL;
      end
      riscv_pkg::DC_REFILL: begin
        if (i_mem_ready) next_state = riscv_pkg::DC_LOOKUP;  // retry as a hit
      end
      riscv_pkg::DC_RESPOND: begin
        next_state = riscv_pkg::DC_IDLE;
      end
      default: next_state = riscv_pkg::DC_IDLE;
    endcase
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      state <= riscv_pkg::DC_IDLE;
      valid <= '0;
      dirty <= '0;
    end else begin
      state <= next_state;
      if (state == riscv_pkg::DC_REFILL && i_mem_ready) begin
        valid[idx] <= 1'b1;
        dirty[idx] <= 1'b0;
      end else if (state == riscv_pkg::DC_LOOKUP && hit && i_dc_wr) begin
        dirty[idx] <= 1'b1;
      end
    end
  end

  // line and tag storage
  always_ff @(posedge i_riscv_clk) begin
    if (state == riscv_pkg::DC_REFILL && i_mem_ready) begin
      data_mem[idx] <= i_mem_rdata;
      tag_mem[idx]  <= tag;
    end else if (state == riscv_pkg::DC_LOOKUP && hit && i_dc_wr) begin
      if (dw_sel) begin
        data_mem[idx][127:64] <= i_dc_wdata;
      end else begin
        data_mem[idx][63:0] <= i_dc_wdata;
      end
    end
  end

  a_done_needs_req: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    o_dc_done |-> (i_dc_rd || i_dc_wr));

endmodule

// ==== rtl/riscv_icache.sv ====
`timescale 1ns/100ps

module riscv_icache (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst_n,
  input  logic                  i_ic_req,
  input  riscv_pkg::addr_t      i_ic_addr,
  output riscv_pkg::instr_t     o_ic_instr,
  output logic                  o_ic_done,
  output logic                  o_mem_rden,
  output riscv_pkg::blk_addr_t  o_mem_addr,
  input  riscv_pkg::block_t     i_mem_rdata,
  input  logic                  i_mem_ready
);

  riscv_pkg::icache_state_t state;

  riscv_pkg::block_t data_mem [riscv_pkg::LINES];
  riscv_pkg::tag_t   tag_mem  [riscv_pkg::LINES];
  logic [riscv_pkg::LINES-1:0] valid;

  riscv_pkg::tag_t   tag;
  riscv_pkg::index_t idx;
  logic [1:0]        word_sel;
  logic              hit;

  assign tag      = i_ic_addr[riscv_pkg::ADDR-1 -: riscv_pkg::TAG];
  assign idx      = i_ic_addr[riscv_pkg::BYTE_OFF +: riscv_pkg::INDEX];
  assign word_sel = i_ic_addr[3:2];
  assign hit      = valid[idx] && (tag_mem[idx] == tag);

  assign o_ic_instr = data_mem[idx][{word_sel, 5'b0} +: 32];
  assign o_ic_done  = (state == riscv_pkg::IC_RESPOND);
  assign o_mem_rden = (state == riscv_pkg::IC_REFILL);
  assign o_mem_addr = {tag, idx};

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      state <= riscv_pkg::IC_IDLE;
      valid <= '0;
    end else begin
      case (state)
        riscv_pkg::IC_IDLE: begin
          if (i_ic_req) state <= riscv_pkg::IC_LOOKUP;
        end
        riscv_pkg::IC_LOOKUP: begin
          state <= hit ? riscv_pkg::IC_RESPOND : riscv_pkg::IC_REFILL;
        end
        riscv_pkg::IC_REFILL: begin
          if (i_mem_ready) begin
            valid[idx] <= 1'b1;
            state      <= riscv_pkg::IC_LOOKUP;
          end
        end
        default: state <= riscv_pkg::IC_IDLE;  // respond lasts one cycle
      endcase
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (state == riscv_pkg::IC_REFILL && i_mem_ready) begin
      data_mem[idx] <= i_mem_rdata;
      tag_mem[idx]  <= tag;
    end
  end

  // fetch address must not move under a pending refill
  a_addr_stable: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    (o_mem_rden && $past(o_mem_rden)) |-> $stable(o_mem_addr));

endmodule

// ==== rtl/riscv_dram_model.sv ====
`timescale 1ns/100ps

module riscv_dram_model (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst_n,
  input  logic                  i_wren,
  input  logic                  i_rden,
  input  riscv_pkg::blk_addr_t  i_addr,
  input  riscv_pkg::block_t     i_wdata,
  output riscv_pkg::block_t     o_rdata,
  output logic                  o_ready
);

  riscv_pkg::block_t           mem [riscv_pkg::MEM_DEPTH];
  logic [riscv_pkg::LAT_W-1:0] lat_cnt;
  logic                        req;

  assign req = i_wren | i_rden;

  initial begin
    for (int i = 0; i < riscv_pkg::MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      lat_cnt <= '0;
      o_ready <= 1'b0;
    end else if (req && !o_ready) begin
      if (lat_cnt == riscv_pkg::LAT_LAST) begin
        lat_cnt <= '0;
        o_ready <= 1'b1;
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end else begin
      lat_cnt <= '0;  // idle or ready cycle
      o_ready <= 1'b0;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (i_rden && !o_ready && lat_cnt == riscv_pkg::LAT_LAST) begin
      o_rdata <= mem[i_addr];  // lands with ready
    end
    if (i_wren && o_ready) begin
      mem[i_addr] <= i_wdata;
    end
  end

  a_one_op: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    !(i_wren && i_rden));

endmodule

// ==== rtl/riscv_iram_model.sv ====
`timescale 1ns/100ps

module riscv_iram_model (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst_n,
  input  logic                  i_rden,
  input  riscv_pkg::blk_addr_t  i_addr,
  output riscv_pkg::block_t     o_rdata,
  output logic                  o_ready
);

  riscv_pkg::block_t           mem [riscv_pkg::MEM_DEPTH];
  logic [riscv_pkg::LAT_W-1:0] lat_cnt;

  // blocks past the hex file read as zero
  initial begin
    for (int i = 0; i < riscv_pkg::MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
    $readmemh("sim/iram.hex", mem);
  end

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      lat_cnt <= '0;
      o_ready <= 1'b0;
    end else if (i_rden && !o_ready) begin
      o_ready <= (lat_cnt == riscv_pkg::LAT_LAST);
      lat_cnt <= (lat_cnt == riscv_pkg::LAT_LAST) ? '0 : lat_cnt + 1'b1;
    end else begin
      lat_cnt <= '0;
      o_ready <= 1'b0;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    if (i_rden && !o_ready && lat_cnt == riscv_pkg::LAT_LAST) o_rdata <= mem[i_addr];
  end

endmodule

// ==== rtl/riscv_mem_top.sv ====
`timescale 1ns/100ps

module riscv_mem_top (
  input  logic               i_riscv_clk,
  input  logic               i_rst_n,
  input  logic               i_dc_rd,
  input  logic               i_dc_wr,
  input  riscv_pkg::addr_t   i_dc_addr,
  input  riscv_pkg::dword_t  i_dc_wdata,
  output riscv_pkg::dword_t  o_dc_rdata,
  output logic               o_dc_done,
  input  logic               i_ic_req,
  input  riscv_pkg::addr_t   i_ic_addr,
  output riscv_pkg::instr_t  o_ic_instr,
  output logic               o_ic_done
);

  // data cache to dram
  logic                  dmem_rden;
  logic                  dmem_wren;
  riscv_pkg::blk_addr_t  dmem_addr;
  riscv_pkg::block_t     dmem_wdata;
  riscv_pkg::block_t     dmem_rdata;
  logic                  dmem_ready;

  // instruction cache to iram
  logic                  imem_rden;
  riscv_pkg::blk_addr_t  imem_addr;
  riscv_pkg::block_t     imem_rdata;
  logic                  imem_ready;

  riscv_dcache u_dcache (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n    ),
    .i_dc_rd     (i_dc_rd    ),
    .i_dc_wr     (i_dc_wr    ),
    .i_dc_addr   (i_dc_addr  ),
    .i_dc_wdata  (i_dc_wdata ),
    .o_dc_rdata  (o_dc_rdata ),
    .o_dc_done   (o_dc_done  ),
    .o_mem_rden  (dmem_rden  ),
    .o_mem_wren  (dmem_wren  ),
    .o_mem_addr  (dmem_addr  ),
    .o_mem_wdata (dmem_wdata ),
    .i_mem_rdata (dmem_rdata ),
    .i_mem_ready (dmem_ready )
  );

  riscv_icache u_icache (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n    ),
    .i_ic_req    (i_ic_req   ),
    .i_ic_addr   (i_ic_addr  ),
    .o_ic_instr  (o_ic_instr ),
    .o_ic_done   (o_ic_done  ),
    .o_mem_rden  (imem_rden  ),
    .o_mem_addr  (imem_addr  ),
    .i_mem_rdata (imem_rdata ),
    .i_mem_ready (imem_ready )
  );

  riscv_dram_model u_dram_model (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n    ),
    .i_wren      (dmem_wren  ),
    .i_rden      (dmem_rden  ),
    .i_addr      (dmem_addr  ),
    .i_wdata     (dmem_wdata ),
    .o_rdata     (dmem_rdata ),
    .o_ready     (dmem_ready )
  );

  riscv_iram_model u_iram_model (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n    ),
    .i_rden      (imem_rden  ),
    .i_addr      (imem_addr  ),
    .o_rdata     (imem_rdata ),
    .o_ready     (imem_ready )
  );

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD = 50;  // 100 ns clock

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // reset held over three rising edges, released on a falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// ==== sim/tb_riscv_mem_top.sv ====
`timescale 1ns/100ps

module tb_riscv_mem_top;

  localparam int FETCH_BLOCKS      = 32;
  localparam int RANDOM_OPS        = 200;
  localparam int CYCLES_PER_ACCESS = 40;
  // every access issued by the tests below
  localparam int NUM_ACCESSES = 1 + 7 + 4 + RANDOM_OPS + 4*FETCH_BLOCKS + 8 + 3 + 2;

  logic                 clk;
  logic                 rst_n;
  logic                 dc_rd;
  logic                 dc_wr;
  riscv_pkg::addr_t     dc_addr;
  riscv_pkg::dword_t    dc_wdata;
  riscv_pkg::dword_t    dc_rdata;
  logic                 dc_done;
  logic                 ic_req;
  riscv_pkg::addr_t     ic_addr;
  riscv_pkg::instr_t    ic_instr;
  logic                 ic_done;

  riscv_pkg::dword_t ref_mem    [2**(riscv_pkg::ADDR-3)];  // one entry per doubleword
  riscv_pkg::block_t iram_image [FETCH_BLOCKS];
  integer            seed;

  tb_clkgen u_clkgen (
    .o_clk   (clk  ),
    .o_rst_n (rst_n)
  );

  riscv_mem_top dut0 (
    .i_riscv_clk (clk     ),
    .i_rst_n     (rst_n   ),
    .i_dc_rd     (dc_rd   ),
    .i_dc_wr     (dc_wr   ),
    .i_dc_addr   (dc_addr ),
    .i_dc_wdata  (dc_wdata),
    .o_dc_rdata  (dc_rdata),
    .o_dc_done   (dc_done ),
    .i_ic_req    (ic_req  ),
    .i_ic_addr   (ic_addr ),
    .o_ic_instr  (ic_instr),
    .o_ic_done   (ic_done )
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, expected);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // blocks past the hex image read as zero
  function automatic riscv_pkg::instr_t expected_instr(input riscv_pkg::addr_t addr);
    riscv_pkg::blk_addr_t blk;
    blk = addr[15:4];
    if (blk < FETCH_BLOCKS) begin
      return iram_image[blk[4:0]][int'(addr[3:2])*32 +: 32];
    end
    return '0;
  endfunction

  task automatic data_write(input riscv_pkg::addr_t addr, input riscv_pkg::dword_t data);
    dc_wr    = 1'b1;
    dc_addr  = addr;
    dc_wdata = data;
    @(negedge clk);
    while (!dc_done) @(negedge clk);
    ref_mem[addr[15:3]] = data;
    @(negedge clk);  // request covers the done cycle
    dc_wr = 1'b0;
  endtask

  task automatic data_read(input riscv_pkg::addr_t addr, input riscv_pkg::dword_t expected);
    dc_rd   = 1'b1;
    dc_addr = addr;
    @(negedge clk);
    while (!dc_done) @(negedge clk);
    check_value("o_dc_rdata", dc_rdata, expected);
    @(negedge clk);
    dc_rd = 1'b0;
  endtask

  task automatic fetch(input riscv_pkg::addr_t addr, input riscv_pkg::instr_t expected);
    ic_req  = 1'b1;
    ic_addr = addr;
    @(negedge clk);
    while (!ic_done) @(negedge clk);
    check_value("o_ic_instr", 64'(ic_instr), 64'(expected));
    @(negedge clk);
    ic_req = 1'b0;
  endtask

  task automatic test_reset_state();
    repeat (4) begin
      check_value("o_dc_done", 64'(dc_done), 64'd0);
      check_value("o_ic_done", 64'(ic_done), 64'd0);
      check_value("mem enables", 64'(dut0.dmem_rden | dut0.dmem_wren | dut0.imem_rden), 64'd0);
      @(negedge clk);
    end
    data_read(16'h0030, 64'd0);  // never written
  endtask

  task automatic test_store_load();
    data_write(16'h0100, 64'h1122_3344_5566_7788);
    data_read(16'h0100, 64'h1122_3344_5566_7788);
    data_read(16'h0108, 64'd0);
    data_read(16'h00f8, 64'd0);
    data_write(16'h0108, 64'hcafe_f00d_0bad_beef);
    data_read(16'h0100, 64'h1122_3344_5566_7788);
    data_read(16'h0108, 64'hcafe_f00d_0bad_beef);
  endtask

  // same index, tag apart by one
  task automatic test_conflict_eviction();
    data_write(16'h0200, 64'h0123_4567_89ab_cdef);
    data_write(16'h0600, 64'hfedc_ba98_7654_3210);
    data_read(16'h0200, 64'h0123_4567_89ab_cdef);
    data_read(16'h0600, 64'hfedc_ba98_7654_3210);
  endtask

  task automatic test_random_sequence();
    logic [31:0]       r;
    riscv_pkg::addr_t  addr;
    riscv_pkg::dword_t data;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r    = $random(seed);
      addr = {r[3:2], 4'b0, 5'b00011, r[1], r[0], 3'b0};  // 4 tags, 2 lines, 2 dwords
      data = {$random(seed), $random(seed)};
      if (r[4]) begin
        data_write(addr, data);
      end else begin
        data_read(addr, ref_mem[addr[15:3]]);
      end
    end
  endtask

  task automatic test_fetch();
    for (int i = 0; i < 4*FETCH_BLOCKS; i++) begin
      fetch(16'(i*4), expected_instr(16'(i*4)));
    end
    for (int i = 0; i < 8; i++) begin
      fetch(16'(i*4), expected_instr(16'(i*4)));  // hits
    end
    fetch(16'h0400, expected_instr(16'h0400));
    fetch(16'h0000, expected_instr(16'h0000));
    fetch(16'h0414, expected_instr(16'h0414));
  endtask

  task automatic test_fetch_and_data();
    fork
      fetch(16'h0018, expected_instr(16'h0018));
      data_read(16'h0600, ref_mem[13'h00c0]);
    join
  endtask

  initial begin
    dc_rd    = 1'b0;
    dc_wr    = 1'b0;
    dc_addr  = '0;
    dc_wdata = '0;
    ic_req   = 1'b0;
    ic_addr  = '0;
    seed     = 50063;
    for (int i = 0; i < 2**(riscv_pkg::ADDR-3); i++) begin
      ref_mem[i] = '0;
    end
    $readmemh("sim/iram.hex", iram_image);

    @(posedge rst_n);
    @(negedge clk);
    test_reset_state();
    test_store_load();
    test_conflict_eviction();
    test_random_sequence();
    test_fetch();
    test_fetch_and_data();

    $display("Test passed");
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_ACCESSES*CYCLES_PER_ACCESS + 10) @(posedge clk);
    $display("ERROR at %0t ns: run timed out waiting for a done pulse", $time);
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== sim/iram.hex ====
// one 128-bit block per line, block 0 first
// word 3 on the left, word 0 on the right
0003fffc0002fffd0001fffe0000ffff
0103fefc0102fefd0101fefe0100feff
0203fdfc0202fdfd0201fdfe0200fdff
0303fcfc0302fcfd0301fcfe0300fcff
0403fbfc0402fbfd0401fbfe0400fbff
0503fafc0502fafd0501fafe0500faff
0603f9fc0602f9fd0601f9fe0600f9ff
0703f8fc0702f8fd0701f8fe0700f8ff
0803f7fc0802f7fd0801f7fe0800f7ff
0903f6fc0902f6fd0901f6fe0900f6ff
0a03f5fc0a02f5fd0a01f5fe0a00f5ff
0b03f4fc0b02f4fd0b01f4fe0b00f4ff
0c03f3fc0c02f3fd0c01f3fe0c00f3ff
0d03f2fc0d02f2fd0d01f2fe0d00f2ff
0e03f1fc0e02f1fd0e01f1fe0e00f1ff
0f03f0fc0f02f0fd0f01f0fe0f00f0ff
1003effc1002effd1001effe1000efff
1103eefc1102eefd1101eefe1100eeff
1203edfc1202edfd1201edfe1200edff
1303ecfc1302ecfd1301ecfe1300ecff
1403ebfc1402ebfd1401ebfe1400ebff
1503eafc1502eafd1501eafe1500eaff
1603e9fc1602e9fd1601e9fe1600e9ff
1703e8fc1702e8fd1701e8fe1700e8ff
1803e7fc1802e7fd1801e7fe1800e7ff
1903e6fc1902e6fd1901e6fe1900e6ff
1a03e5fc1a02e5fd1a01e5fe1a00e5ff
1b03e4fc1b02e4fd1b01e4fe1b00e4ff
1c03e3fc1c02e3fd1c01e3fe1c00e3ff
1d03e2fc1d02e2fd1d01e2fe1d00e2ff
1e03e1fc1e02e1fd1e01e1fe1e00e1ff
1f03e0fc1f02e0fd1f01e0fe1f00e0ff

// ==== tb.f ====
rtl/riscv_pkg.sv
rtl/riscv_dcache.sv
rtl/riscv_icache.sv
rtl/riscv_dram_model.sv
rtl/riscv_iram_model.sv
rtl/riscv_mem_top.sv
sim/tb_clkgen.sv
sim/tb_riscv_mem_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from tb.f and run, output in sim.log"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_riscv_mem_top -Mdir obj_dir
	./obj_dir/Vtb_riscv_mem_top > sim.log 2>&1 || true
	@if grep -q "^Test passed$$" sim.log; then \
	  echo "simulation ok"; \
	else \
	  echo "simulation failed, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
